// File: hdl/cpu_pkg.sv
package cpu_pkg;

	localparam int DATA_W = 32;

	// link register written by jal.
	localparam logic [4:0] LP_REG = 5'd30;

	// instruction field positions.
	localparam int OP_MSB  = 30;
	localparam int OP_LSB  = 25;
	localparam int RT_MSB  = 24;
	localparam int RT_LSB  = 20;
	localparam int RA_MSB  = 19;
	localparam int RA_LSB  = 15;
	localparam int RB_MSB  = 14;
	localparam int RB_LSB  = 10;
	localparam int SV_MSB  = 9;
	localparam int SV_LSB  = 8;
	localparam int SUB_MSB = 4;
	localparam int SUB_LSB = 0;

	typedef enum logic [5:0] {
		OP_LWI   = 6'b000010,
		OP_SWI   = 6'b001010,
		OP_LW    = 6'b011100,
		OP_ALU_1 = 6'b100000,
		OP_MOVI  = 6'b100010,
		OP_SETHI = 6'b100011,
		OP_JAL   = 6'b100100,
		OP_ADDI  = 6'b101000,
		OP_ORI   = 6'b101100
	} opcode_e;

	typedef enum logic [4:0] {
		SUB_ADD  = 5'b00000,
		SUB_SUB  = 5'b00001,
		SUB_AND  = 5'b00010,
		SUB_XOR  = 5'b00011,
		SUB_OR   = 5'b00100,
		SUB_SLLI = 5'b01000,
		SUB_SRLI = 5'b01001
	} alu_sub_e;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL
	} alu_op_e;

	typedef enum logic [1:0] {SRC2_RB, SRC2_IMM, SRC2_LSWI, SRC2_LSW} alu_src2_e;

	typedef enum logic [2:0] {
		IMM_5BIT_ZE, IMM_15BIT_SE, IMM_15BIT_ZE, IMM_20BIT_SE, IMM_20BIT_HI
	} imm_sel_e;

	typedef enum logic {WRADDR_RT, WRADDR_LP} wr_addr_e;

	typedef enum logic [1:0] {WRREG_ALU, WRREG_IMM, WRREG_MEM, WRREG_PC} wr_data_e;

endpackage

// File: hdl/alu.sv
`timescale 1ns/100ps

module alu (
	input  cpu_pkg::alu_op_e            alu_op,
	input  logic [cpu_pkg::DATA_W-1:0]  src1,
	input  logic [cpu_pkg::DATA_W-1:0]  src2,
	output logic [cpu_pkg::DATA_W-1:0]  result
);

	logic [4:0] shamt;

	assign shamt = src2[4:0];

	always_comb begin
		case (alu_op)
			cpu_pkg::ALU_ADD: result = src1 + src2;
			cpu_pkg::ALU_SUB: result = src1 - src2;
			cpu_pkg::ALU_AND: result = src1 & src2;
			cpu_pkg::ALU_OR:  result = src1 | src2;
			cpu_pkg::ALU_XOR: result = src1 ^ src2;
			cpu_pkg::ALU_SLL: result = src1 << shamt;
			// logical, zeros shift in.
			cpu_pkg::ALU_SRL: result = src1 >> shamt;
			default:          result = src1 + src2;
		endcase
	end

endmodule

// File: hdl/decoder.sv
`timescale 1ns/100ps

module decoder (
	input  logic                instr_valid,
	input  logic [31:0]         instr,
	output cpu_pkg::alu_op_e    alu_op,
	output cpu_pkg::alu_src2_e  alu_src2_sel,
	output cpu_pkg::imm_sel_e   imm_sel,
	output cpu_pkg::wr_addr_e   wr_addr_sel,
	output cpu_pkg::wr_data_e   wr_data_sel,
	output logic                reg_write,
	output logic                mem_write,
	output logic                is_jump,
	output logic                is_illegal
);

	cpu_pkg::opcode_e  opcode;
	cpu_pkg::alu_sub_e sub_op;
	logic dec_write;
	logic dec_store;
	logic dec_jump;
	logic dec_bad;

	assign opcode = cpu_pkg::opcode_e'(instr[cpu_pkg::OP_MSB:cpu_pkg::OP_LSB]);
	assign sub_op = cpu_pkg::alu_sub_e'(instr[cpu_pkg::SUB_MSB:cpu_pkg::SUB_LSB]);

	always_comb begin
		alu_op       = cpu_pkg::ALU_ADD;
		alu_src2_sel = cpu_pkg::SRC2_RB;
		imm_sel      = cpu_pkg::IMM_15BIT_SE;
		wr_addr_sel  = cpu_pkg::WRADDR_RT;
		wr_data_sel  = cpu_pkg::WRREG_ALU;
		dec_write    = 1'b1;
		dec_store    = 1'b0;
		dec_jump     = 1'b0;
		dec_bad      = 1'b0;
		case (opcode)
			cpu_pkg::OP_ALU_1: begin
				case (sub_op)
					cpu_pkg::SUB_ADD: alu_op = cpu_pkg::ALU_ADD;
					cpu_pkg::SUB_SUB: alu_op = cpu_pkg::ALU_SUB;
					cpu_pkg::SUB_AND: alu_op = cpu_pkg::ALU_AND;
					cpu_pkg::SUB_OR:  alu_op = cpu_pkg::ALU_OR;
					cpu_pkg::SUB_XOR: alu_op = cpu_pkg::ALU_XOR;
					cpu_pkg::SUB_SLLI, cpu_pkg::SUB_SRLI: begin
						// shift amount comes from the rb field.
						alu_op = (sub_op == cpu_pkg::SUB_SLLI) ?
							cpu_pkg::ALU_SLL : cpu_pkg::ALU_SRL;
						alu_src2_sel = cpu_pkg::SRC2_IMM;
						imm_sel      = cpu_pkg::IMM_5BIT_ZE;
					end
					default: dec_bad = 1'b1;
				endcase
			end
			cpu_pkg::OP_ADDI: begin
				alu_src2_sel = cpu_pkg::SRC2_IMM;
			end
			cpu_pkg::OP_ORI: begin
				alu_op       = cpu_pkg::ALU_OR;
				alu_src2_sel = cpu_pkg::SRC2_IMM;
				imm_sel      = cpu_pkg::IMM_15BIT_ZE;
			end
			cpu_pkg::OP_MOVI, cpu_pkg::OP_SETHI: begin
				imm_sel = (opcode == cpu_pkg::OP_MOVI) ?
					cpu_pkg::IMM_20BIT_SE : cpu_pkg::IMM_20BIT_HI;
				wr_data_sel = cpu_pkg::WRREG_IMM;
			end
			cpu_pkg::OP_LWI: begin
				alu_src2_sel = cpu_pkg::SRC2_LSWI;
				wr_data_sel  = cpu_pkg::WRREG_MEM;
			end
			cpu_pkg::OP_SWI: begin
				alu_src2_sel = cpu_pkg::SRC2_LSWI;
				dec_write    = 1'b0;
				dec_store    = 1'b1;
			end
			cpu_pkg::OP_LW: begin
				alu_src2_sel = cpu_pkg::SRC2_LSW;
				wr_data_sel  = cpu_pkg::WRREG_MEM;
			end
			cpu_pkg::OP_JAL: begin
				wr_addr_sel = cpu_pkg::WRADDR_LP;
				wr_data_sel = cpu_pkg::WRREG_PC;
				dec_jump    = 1'b1;
			end
			default: dec_bad = 1'b1;
		endcase
	end

	// an undefined code turns into a bubble.
	assign reg_write  = instr_valid & dec_write & ~dec_bad;
	assign mem_write  = instr_valid & dec_store;
	assign is_jump    = instr_valid & dec_jump;
	assign is_illegal = instr_valid & dec_bad;

endmodule

// File: hdl/operand_muxes.sv
`timescale 1ns/100ps

module operand_muxes (
	input  logic [1:0]                  sub_op_sv,
	input  logic [cpu_pkg::DATA_W-1:0]  reg_rb_data,
	input  logic [4:0]                  reg_rt_addr,
	input  logic [4:0]                  imm_5bit,
	input  logic [14:0]                 imm_15bit,
	input  logic [19:0]                 imm_20bit,
	input  cpu_pkg::alu_src2_e          alu_src2_sel,
	input  cpu_pkg::imm_sel_e           imm_sel,
	input  cpu_pkg::wr_addr_e           wr_addr_sel,
	input  cpu_pkg::wr_data_e           xreg3_wr_data_sel,
	input  logic [cpu_pkg::DATA_W-1:0]  xreg3_alu_result,
	input  logic [cpu_pkg::DATA_W-1:0]  xreg3_imm_extend,
	input  logic [cpu_pkg::DATA_W-1:0]  mem_read_data,
	input  logic [31:0]                 xreg3_return_pc,
	output logic [cpu_pkg::DATA_W-1:0]  imm_extend,
	output logic [cpu_pkg::DATA_W-1:0]  alu_src2,
	output logic [4:0]                  write_reg_addr,
	output logic [cpu_pkg::DATA_W-1:0]  write_reg_data
);

	always_comb begin
		case (imm_sel)
			cpu_pkg::IMM_5BIT_ZE:  imm_extend = {27'b0, imm_5bit};
			cpu_pkg::IMM_15BIT_SE: imm_extend = {{17{imm_15bit[14]}}, imm_15bit};
			cpu_pkg::IMM_15BIT_ZE: imm_extend = {17'b0, imm_15bit};
			cpu_pkg::IMM_20BIT_SE: imm_extend = {{12{imm_20bit[19]}}, imm_20bit};
			cpu_pkg::IMM_20BIT_HI: imm_extend = {imm_20bit, 12'b0};
			default:               imm_extend = '0;
		endcase
	end

	always_comb begin
		case (alu_src2_sel)
			cpu_pkg::SRC2_RB:   alu_src2 = reg_rb_data;
			cpu_pkg::SRC2_IMM:  alu_src2 = imm_extend;
			// word offset for lwi and swi.
			cpu_pkg::SRC2_LSWI: alu_src2 = {{15{imm_15bit[14]}}, imm_15bit, 2'b00};
			cpu_pkg::SRC2_LSW:  alu_src2 = reg_rb_data << sub_op_sv;
			default:            alu_src2 = reg_rb_data;
		endcase
	end

	assign write_reg_addr = (wr_addr_sel == cpu_pkg::WRADDR_LP) ? cpu_pkg::LP_REG : reg_rt_addr;

	// stage 2 side, also feeds the register file bypass.
	always_comb begin
		case (xreg3_wr_data_sel)
			cpu_pkg::WRREG_ALU: write_reg_data = xreg3_alu_result;
			cpu_pkg::WRREG_IMM: write_reg_data = xreg3_imm_extend;
			cpu_pkg::WRREG_MEM: write_reg_data = mem_read_data;
			cpu_pkg::WRREG_PC:  write_reg_data = xreg3_return_pc;
			default:            write_reg_data = xreg3_alu_result;
		endcase
	end

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/100ps

module reg_file (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [4:0]                  ra_addr,
	input  logic [4:0]                  rb_addr,
	input  logic [4:0]                  rt_addr,
	input  logic                        write_en,
	input  logic [4:0]                  write_addr,
	input  logic [cpu_pkg::DATA_W-1:0]  write_data,
	output logic [cpu_pkg::DATA_W-1:0]  ra_data,
	output logic [cpu_pkg::DATA_W-1:0]  rb_data,
	output logic [cpu_pkg::DATA_W-1:0]  rt_data
);

	logic [cpu_pkg::DATA_W-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en) begin
			regs[write_addr] <= write_data;
		end
	end

	// write-through so stage 1 sees the result still in stage 2.
	assign ra_data = (write_en && write_addr == ra_addr) ? write_data : regs[ra_addr];
	assign rb_data = (write_en && write_addr == rb_addr) ? write_data : regs[rb_addr];
	assign rt_data = (write_en && write_addr == rt_addr) ? write_data : regs[rt_addr];

endmodule

// File: hdl/pipe_regs.sv
`timescale 1ns/100ps

module pipe_regs (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        instr_valid,
	input  logic                        is_jump,
	input  logic                        is_illegal,
	input  logic [23:0]                 imm_24bit,
	input  logic                        reg_write,
	input  logic                        mem_write,
	input  cpu_pkg::wr_data_e           wr_data_sel,
	input  logic [cpu_pkg::DATA_W-1:0]  alu_result,
	input  logic [cpu_pkg::DATA_W-1:0]  imm_extend,
	input  logic [cpu_pkg::DATA_W-1:0]  rt_data,
	input  logic [4:0]                  write_reg_addr,
	output logic [31:0]                 pc,
	output logic                        xreg3_reg_write,
	output logic                        xreg3_mem_write,
	output cpu_pkg::wr_data_e           xreg3_wr_data_sel,
	output logic [cpu_pkg::DATA_W-1:0]  xreg3_alu_result,
	output logic [cpu_pkg::DATA_W-1:0]  xreg3_imm_extend,
	output logic [cpu_pkg::DATA_W-1:0]  xreg3_store_data,
	output logic [4:0]                  xreg3_write_reg_addr,
	output logic [31:0]                 xreg3_return_pc,
	output logic                        illegal
);

	logic [31:0] pc_plus4;
	logic [31:0] jump_target;

	assign pc_plus4    = pc + 32'd4;
	assign jump_target = pc + {{7{imm_24bit[23]}}, imm_24bit, 1'b0};

	// an illegal instruction leaves the pc where it is.
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else if (instr_valid && !is_illegal) begin
			pc <= is_jump ? jump_target : pc_plus4;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			xreg3_reg_write <= 1'b0;
			xreg3_mem_write <= 1'b0;
			illegal         <= 1'b0;
		end else begin
			xreg3_reg_write <= reg_write;
			xreg3_mem_write <= mem_write;
			illegal         <= is_illegal;
		end
	end

	always_ff @(posedge clk) begin
		xreg3_wr_data_sel    <= wr_data_sel;
		xreg3_alu_result     <= alu_result;
		xreg3_imm_extend     <= imm_extend;
		xreg3_store_data     <= rt_data;
		xreg3_write_reg_addr <= write_reg_addr;
		xreg3_return_pc      <= pc_plus4;
	end

endmodule

// File: hdl/data_mem.sv
`timescale 1ns/100ps

module data_mem #(
	parameter int MEM_WORDS = 64
) (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        write_en,
	input  logic [31:0]                 address,
	input  logic [cpu_pkg::DATA_W-1:0]  write_data,
	output logic [cpu_pkg::DATA_W-1:0]  read_data
);

	localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

	logic [cpu_pkg::DATA_W-1:0] mem [MEM_WORDS];
	logic [IDX_W-1:0] index;

	// byte address, word granular, wraps at the depth.
	assign index = IDX_W'(address[31:2] % MEM_WORDS);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < MEM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (write_en) begin
			mem[index] <= write_data;
		end
	end

	assign read_data = mem[index];

endmodule

// File: hdl/cpu_core.sv
`timescale 1ns/100ps

module cpu_core #(
	parameter int MEM_WORDS = 64
) (
	input  logic         clk,
	input  logic         reset,
	input  logic         instr_valid,
	input  logic [31:0]  instr,
	output logic [31:0]  pc,
	output logic         wb_valid,
	output logic [4:0]   wb_addr,
	output logic [31:0]  wb_data,
	output logic         illegal
);

	cpu_pkg::alu_op_e   alu_op;
	cpu_pkg::alu_src2_e alu_src2_sel;
	cpu_pkg::imm_sel_e  imm_sel;
	cpu_pkg::wr_addr_e  wr_addr_sel;
	cpu_pkg::wr_data_e  wr_data_sel;
	cpu_pkg::wr_data_e  xreg3_wr_data_sel;
	logic reg_write;
	logic mem_write;
	logic is_jump;
	logic is_illegal;
	logic xreg3_mem_write;
	logic [cpu_pkg::DATA_W-1:0] ra_data;
	logic [cpu_pkg::DATA_W-1:0] rb_data;
	logic [cpu_pkg::DATA_W-1:0] rt_data;
	logic [cpu_pkg::DATA_W-1:0] imm_extend;
	logic [cpu_pkg::DATA_W-1:0] alu_src2;
	logic [cpu_pkg::DATA_W-1:0] alu_result;
	logic [cpu_pkg::DATA_W-1:0] mem_read_data;
	logic [cpu_pkg::DATA_W-1:0] xreg3_alu_result;
	logic [cpu_pkg::DATA_W-1:0] xreg3_imm_extend;
	logic [cpu_pkg::DATA_W-1:0] xreg3_store_data;
	logic [31:0] xreg3_return_pc;
	logic [4:0] write_reg_addr;

	decoder u_decoder (
		.instr_valid(instr_valid), .instr(instr), .alu_op(alu_op),
		.alu_src2_sel(alu_src2_sel), .imm_sel(imm_sel), .wr_addr_sel(wr_addr_sel),
		.wr_data_sel(wr_data_sel), .reg_write(reg_write), .mem_write(mem_write),
		.is_jump(is_jump), .is_illegal(is_illegal)
	);

	// write port is fed from stage 2.
	reg_file u_reg_file (
		.clk(clk), .reset(reset),
		.ra_addr(instr[cpu_pkg::RA_MSB:cpu_pkg::RA_LSB]),
		.rb_addr(instr[cpu_pkg::RB_MSB:cpu_pkg::RB_LSB]),
		.rt_addr(instr[cpu_pkg::RT_MSB:cpu_pkg::RT_LSB]),
		.write_en(wb_valid), .write_addr(wb_addr), .write_data(wb_data),
		.ra_data(ra_data), .rb_data(rb_data), .rt_data(rt_data)
	);

	operand_muxes u_operand_muxes (
		.sub_op_sv(instr[cpu_pkg::SV_MSB:cpu_pkg::SV_LSB]), .reg_rb_data(rb_data),
		.reg_rt_addr(instr[cpu_pkg::RT_MSB:cpu_pkg::RT_LSB]),
		.imm_5bit(instr[cpu_pkg::RB_MSB:cpu_pkg::RB_LSB]), .imm_15bit(instr[14:0]),
		.imm_20bit(instr[19:0]), .alu_src2_sel(alu_src2_sel), .imm_sel(imm_sel),
		.wr_addr_sel(wr_addr_sel), .xreg3_wr_data_sel(xreg3_wr_data_sel),
		.xreg3_alu_result(xreg3_alu_result), .xreg3_imm_extend(xreg3_imm_extend),
		.mem_read_data(mem_read_data), .xreg3_return_pc(xreg3_return_pc),
		.imm_extend(imm_extend), .alu_src2(alu_src2),
		.write_reg_addr(write_reg_addr), .write_reg_data(wb_data)
	);

	alu u_alu (.alu_op(alu_op), .src1(ra_data), .src2(alu_src2), .result(alu_result));

	pipe_regs u_pipe_regs (
		.clk(clk), .reset(reset), .instr_valid(instr_valid), .is_jump(is_jump),
		.is_illegal(is_illegal), .imm_24bit(instr[23:0]), .reg_write(reg_write),
		.mem_write(mem_write), .wr_data_sel(wr_data_sel), .alu_result(alu_result),
		.imm_extend(imm_extend), .rt_data(rt_data), .write_reg_addr(write_reg_addr),
		.pc(pc), .xreg3_reg_write(wb_valid), .xreg3_mem_write(xreg3_mem_write),
		.xreg3_wr_data_sel(xreg3_wr_data_sel), .xreg3_alu_result(xreg3_alu_result),
		.xreg3_imm_extend(xreg3_imm_extend), .xreg3_store_data(xreg3_store_data),
		.xreg3_write_reg_addr(wb_addr), .xreg3_return_pc(xreg3_return_pc),
		.illegal(illegal)
	);

	data_mem #(.MEM_WORDS(MEM_WORDS)) u_data_mem (
		.clk(clk), .reset(reset), .write_en(xreg3_mem_write),
		.address(xreg3_alu_result), .write_data(xreg3_store_data),
		.read_data(mem_read_data)
	);

endmodule

// File: tb/cpu_sva.sv
`timescale 1ns/100ps

module cpu_sva (
	input logic        clk,
	input logic        reset,
	input logic        wb_valid,
	input logic [4:0]  wb_addr,
	input logic [31:0] wb_data,
	input logic        illegal
);

	// a bubble never writes back.
	wb_vs_illegal: assert property (@(posedge clk) disable iff (reset)
		!(wb_valid && illegal))
		else $error("wb_valid and illegal are high in the same cycle");

	wb_known: assert property (@(posedge clk) disable iff (reset)
		wb_valid |-> !$isunknown({wb_addr, wb_data}))
		else $error("write-back address or data unknown while wb_valid is high");

	quiet_after_reset: assert property (@(posedge clk)
		reset |=> (!wb_valid && !illegal))
		else $error("wb_valid or illegal high in the cycle after reset");

endmodule

bind cpu_core cpu_sva u_cpu_sva (
	.clk(clk),
	.reset(reset),
	.wb_valid(wb_valid),
	.wb_addr(wb_addr),
	.wb_data(wb_data),
	.illegal(illegal)
);

// File: tb/cpu_tb.sv
`timescale 1ns/100ps

module cpu_tb;

	localparam int MEM_WORDS    = 64;
	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CYCLES = 5;
	localparam int NUM_SLOTS    = 2000;
	localparam int DRIVE_DELAY  = 2;
	localparam int SAMPLE_DELAY = 1;
	localparam int TIMEOUT_NS   = (NUM_SLOTS + RESET_CYCLES + 100) * CLK_PERIOD;

	logic        clk;
	logic        reset;
	logic        instr_valid;
	logic [31:0] instr;
	logic [31:0] pc;
	logic        wb_valid;
	logic [4:0]  wb_addr;
	logic [31:0] wb_data;
	logic        illegal;

	logic [31:0] lcg_state;
	logic [31:0] model_regs [32];
	logic [31:0] model_mem [MEM_WORDS];
	logic [31:0] model_pc;

	cpu_core #(.MEM_WORDS(MEM_WORDS)) DUT (
		.clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr),
		.pc(pc), .wb_valid(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data),
		.illegal(illegal)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] rand_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return {16'b0, lcg_state[30:15]};
	endfunction

	function automatic logic [31:0] rand_word();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = rand_next();
		lo = rand_next();
		return {hi[15:0], lo[15:0]};
	endfunction

	// few registers, so results get reused often.
	function automatic logic [4:0] pick_reg();
		logic [31:0] r;
		r = rand_next() % 32'd9;
		return (r == 32'd8) ? cpu_pkg::LP_REG : r[4:0];
	endfunction

	function automatic logic [4:0] pick_sub();
		case (rand_next() % 32'd7)
			32'd0: return cpu_pkg::SUB_ADD;
			32'd1: return cpu_pkg::SUB_SUB;
			32'd2: return cpu_pkg::SUB_AND;
			32'd3: return cpu_pkg::SUB_OR;
			32'd4: return cpu_pkg::SUB_XOR;
			32'd5: return cpu_pkg::SUB_SLLI;
			default: return cpu_pkg::SUB_SRLI;
		endcase
	endfunction

	function automatic int mem_index(input logic [31:0] addr);
		logic [31:0] word_addr;
		word_addr = {2'b00, addr[31:2]};
		return int'(word_addr % MEM_WORDS);
	endfunction

	function automatic logic [31:0] make_instr(input logic force_load);
		logic [31:0] word;
		logic [31:0] pick;
		logic [5:0]  op;
		logic        bad_sub;
		word = rand_word();
		bad_sub = 1'b0;
		pick = force_load ? 32'd60 : rand_next() % 32'd100;
		if (pick < 32'd30) op = cpu_pkg::OP_ALU_1;
		else if (pick < 32'd40) op = cpu_pkg::OP_ADDI;
		else if (pick < 32'd46) op = cpu_pkg::OP_ORI;
		else if (pick < 32'd53) op = cpu_pkg::OP_MOVI;
		else if (pick < 32'd58) op = cpu_pkg::OP_SETHI;
		else if (pick < 32'd70) op = cpu_pkg::OP_LWI;
		else if (pick < 32'd82) op = cpu_pkg::OP_SWI;
		else if (pick < 32'd90) op = cpu_pkg::OP_LW;
		else if (pick < 32'd96) op = cpu_pkg::OP_JAL;
		else begin
			pick = rand_next() % 32'd4;
			op = (pick == 32'd0) ? 6'h3f : (pick == 32'd1) ? 6'h15 :
				(pick == 32'd2) ? 6'h00 : cpu_pkg::OP_ALU_1;
			bad_sub = (pick == 32'd3);
		end
		word[31] = 1'b0;
		word[30:25] = op;
		// immediate-only formats keep their random fields.
		if (op != cpu_pkg::OP_JAL && op != cpu_pkg::OP_MOVI && op != cpu_pkg::OP_SETHI) begin
			word[24:20] = pick_reg();
			word[19:15] = pick_reg();
		end
		if (op == cpu_pkg::OP_ALU_1 || op == cpu_pkg::OP_LW)
			word[14:10] = pick_reg();
		if (op == cpu_pkg::OP_ALU_1)
			word[4:0] = bad_sub ? 5'h1f : pick_sub();
		return word;
	endfunction

	task automatic model_step(input logic [31:0] word, output logic exp_wb,
			output logic [4:0] exp_addr, output logic [31:0] exp_data,
			output logic exp_illegal);
		logic [5:0]  op;
		logic [4:0]  rb;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] word_offset;
		op = word[30:25];
		rb = word[14:10];
		a = model_regs[word[19:15]];
		b = model_regs[rb];
		word_offset = {{15{word[14]}}, word[14:0], 2'b00};
		exp_wb = 1'b1;
		exp_addr = word[24:20];
		exp_data = '0;
		exp_illegal = 1'b0;
		case (op)
			cpu_pkg::OP_ALU_1: begin
				case (word[4:0])
					cpu_pkg::SUB_ADD:  exp_data = a + b;
					cpu_pkg::SUB_SUB:  exp_data = a - b;
					cpu_pkg::SUB_AND:  exp_data = a & b;
					cpu_pkg::SUB_OR:   exp_data = a | b;
					cpu_pkg::SUB_XOR:  exp_data = a ^ b;
					cpu_pkg::SUB_SLLI: exp_data = a << rb;
					cpu_pkg::SUB_SRLI: exp_data = a >> rb;
					default:           exp_illegal = 1'b1;
				endcase
			end
			cpu_pkg::OP_ADDI:  exp_data = a + {{17{word[14]}}, word[14:0]};
			cpu_pkg::OP_ORI:   exp_data = a | {17'b0, word[14:0]};
			cpu_pkg::OP_MOVI:  exp_data = {{12{word[19]}}, word[19:0]};
			cpu_pkg::OP_SETHI: exp_data = {word[19:0], 12'b0};
			cpu_pkg::OP_LWI:   exp_data = model_mem[mem_index(a + word_offset)];
			cpu_pkg::OP_LW:    exp_data = model_mem[mem_index(a + (b << word[9:8]))];
			cpu_pkg::OP_SWI: begin
				model_mem[mem_index(a + word_offset)] = model_regs[word[24:20]];
				exp_wb = 1'b0;
			end
			cpu_pkg::OP_JAL: begin
				exp_addr = cpu_pkg::LP_REG;
				exp_data = model_pc + 32'd4;
			end
			default: exp_illegal = 1'b1;
		endcase
		if (exp_illegal)
			exp_wb = 1'b0;
		if (exp_wb)
			model_regs[exp_addr] = exp_data;
		if (op == cpu_pkg::OP_JAL)
			model_pc = model_pc + {{7{word[23]}}, word[23:0], 1'b0};
		else if (!exp_illegal)
			model_pc = model_pc + 32'd4;
	endtask

	function automatic string test_name(input logic valid, input logic [31:0] word);
		if (!valid)
			return "idle slot";
		case (word[30:25])
			cpu_pkg::OP_LWI, cpu_pkg::OP_LW: return "load";
			cpu_pkg::OP_SWI: return "store";
			cpu_pkg::OP_JAL: return "jal";
			default: return "alu op";
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("** Error [%s] expected %h actual %h", name, expected, actual);
			$display(">>> FAIL");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	initial begin
		logic        valid;
		logic [31:0] word;
		logic        exp_wb;
		logic [4:0]  exp_addr;
		logic [31:0] exp_data;
		logic        exp_illegal;
		logic        last_wb;
		logic [4:0]  last_dest;
		string       name;
		lcg_state = 32'd43161;
		reset = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		model_pc = '0;
		last_wb = 1'b0;
		last_dest = '0;
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		for (int i = 0; i < MEM_WORDS; i++)
			model_mem[i] = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#(DRIVE_DELAY);
		reset = 1'b0;
		@(posedge clk);
		#(SAMPLE_DELAY);
		check_value("reset pc", 32'd0, pc);
		check_value("reset wb_valid", 32'd0, {31'b0, wb_valid});
		check_value("reset illegal", 32'd0, {31'b0, illegal});
		#(DRIVE_DELAY - SAMPLE_DELAY);
		for (int slot = 0; slot < NUM_SLOTS; slot++) begin
			// the first slots load from a freshly cleared memory.
			valid = (slot < 4) || ((rand_next() % 32'd100) < 32'd80);
			word = make_instr(slot < 4);
			instr_valid = valid;
			instr = word;
			exp_wb = 1'b0;
			exp_addr = '0;
			exp_data = '0;
			exp_illegal = 1'b0;
			if (valid)
				model_step(word, exp_wb, exp_addr, exp_data, exp_illegal);
			if (exp_illegal)
				name = "illegal opcode";
			else
				name = test_name(valid, word);
			if (valid && last_wb && (word[19:15] == last_dest || word[14:10] == last_dest ||
					word[24:20] == last_dest))
				name = {name, " after dependence"};
			@(posedge clk);
			#(SAMPLE_DELAY);
			check_value({name, " pc"}, model_pc, pc);
			check_value({name, " wb_valid"}, {31'b0, exp_wb}, {31'b0, wb_valid});
			check_value({name, " illegal"}, {31'b0, exp_illegal}, {31'b0, illegal});
			if (exp_wb) begin
				check_value({name, " wb_addr"}, {27'b0, exp_addr}, {27'b0, wb_addr});
				check_value({name, " wb_data"}, exp_data, wb_data);
			end
			last_wb = exp_wb;
			last_dest = exp_addr;
			#(DRIVE_DELAY - SAMPLE_DELAY);
		end
		instr_valid = 1'b0;
		$display(">>> PASS");
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired, the instruction sequence did not finish in time");
		$display(">>> FAIL");
		$fatal(1, "watchdog timeout");
	end

endmodule

// File: project.f
hdl/cpu_pkg.sv
hdl/alu.sv
hdl/decoder.sv
hdl/operand_muxes.sv
hdl/reg_file.sv
hdl/pipe_regs.sv
hdl/data_mem.sv
hdl/cpu_core.sv
tb/cpu_sva.sv
tb/cpu_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
LINTFLAGS = --lint-only --timing --assert --timescale 1ns/100ps
TOP       = cpu_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '>>> PASS'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
